//--- dds_scope_top.f
rtl/dds_lab_pkg.sv
rtl/scan_code_pkg.sv
rtl/held_key_tracker.sv
rtl/strobe_divider.sv
rtl/lfsr_prbs.sv
rtl/dds_modulator.sv
rtl/scope_sampler.sv
rtl/dds_scope_top.sv
dv/dds_scope_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DDS scope testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f dds_scope_top.f \
   --top-module dds_scope_tb \
   -o dds_scope_sim

./obj_dir/dds_scope_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

//--- dv/dds_scope_tb.sv
`default_nettype none
`timescale 1ns/1ps

module dds_scope_tb
   import dds_lab_pkg::*;
   import scan_code_pkg::*;
();

   localparam int LFSR_DIV    = 7;
   localparam int SCOPE_DIV   = 5;
   localparam int KEY_CYCLES  = 400;
   localparam int WAVE_CYCLES = 250;            // per waveform
   localparam int MOD_CYCLES  = 300;            // per modulation code
   localparam int LFSR_CYCLES = 64 * LFSR_DIV;  // two prbs periods and margin
   localparam int LIVE_CYCLES = 500;
   localparam int TIMEOUT_CYCLES = 2 * (30 + KEY_CYCLES + 4 * WAVE_CYCLES
                                        + 3 * MOD_CYCLES + LFSR_CYCLES + LIVE_CYCLES);

   logic               CLK_25MHZ;
   logic               reset_from_key;
   logic               key_event_valid;
   logic [7:0]         key_event;
   logic [PHASE_W-1:0] tuning_word;
   wave_sel_t          wave_sel;
   mod_sel_t           mod_sel;
   held_keys_t         held_keys;
   scope_trace_t       scope_trace;
   logic               trace_valid;

   string              test_name;
   logic [31:0]        rng_state   = 32'd2;
   int                 cycle_count = 0;
   logic               checking    = 1'b0;

   ////////////////////
   // cycle model state

   int                   lfsr_cnt;
   int                   scope_cnt;
   logic                 lfsr_stb;
   logic                 scope_stb;
   logic [4:0]           m_lfsr;
   logic [PHASE_W-1:0]   m_phase;
   dds_sample_t          m_samples;
   scope_trace_t         m_trace;
   logic                 m_valid;
   logic [KEY_COUNT-1:0] m_keys;
   int                   m_step_count;    // lfsr steps since reset
   int                   m_samples_step;  // step count behind the sample register
   int                   m_trace_step;    // step count behind the trace register

   dds_scope_top #(
      .LFSR_DIVIDE  (LFSR_DIV),
      .SCOPE_DIVIDE (SCOPE_DIV)
   ) dds_scope_top_i (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .tuning_word     (tuning_word),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .held_keys       (held_keys),
      .scope_trace     (scope_trace),
      .trace_valid     (trace_valid)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;  // 25 MHz
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // p is the top 12 phase bits and the result a signed 12 bit sample
   function automatic logic [11:0] wave_value(input wave_sel_t wsel, input logic [31:0] ph);
      int p;
      int q;
      int v;
      p = int'(ph[31:20]);
      q = (p % 2048) * 2;
      case (wsel)
         WAVE_SAW:      v = p - 2048;
         WAVE_SQUARE:   v = (p < 2048) ? 2047 : -2048;
         WAVE_TRIANGLE: v = (p < 2048) ? q - 2048 : 2047 - q;
         default:       v = 0;
      endcase
      return v[11:0];
   endfunction

   function automatic logic [11:0] modulate_value(input mod_sel_t msel, input logic [11:0] orig,
                                                  input logic prbs);
      int s;
      s = int'($signed(orig));
      case (msel)
         MOD_ASK:  s = prbs ? s : 0;
         MOD_BPSK: s = prbs ? s : -s - 1;  // bitwise inversion in two's complement
         default:  s = s;
      endcase
      return s[11:0];
   endfunction

   function automatic logic [7:0] trace_value(input logic [11:0] sample);
      int u;
      u = int'($signed(sample)) + 2048;  // offset binary from 0 to 4095
      return u[11:4];
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("error %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
         $display("** FAIL **");
         $fatal(1, "mismatch in %s", test_name);
      end
   endtask

   ////////////////////
   // model advanced on every rising edge from the inputs before the edge

   always @(posedge CLK_25MHZ)
   begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
      if (reset_from_key)
      begin
         lfsr_cnt       = 0;
         scope_cnt      = 0;
         lfsr_stb       = 1'b0;
         scope_stb      = 1'b0;
         m_lfsr         = 5'b00001;
         m_phase        = '0;
         m_samples      = '0;
         m_trace        = '0;
         m_valid        = 1'b0;
         m_keys         = '0;
         m_step_count   = 0;
         m_samples_step = 0;
         m_trace_step   = 0;
      end
      else
      begin
         m_valid = scope_stb;  // strobe of the previous cycle
         if (scope_stb)
         begin
            m_trace.modulated_trace = trace_value(m_samples.modulated);
            m_trace.original_trace  = trace_value(m_samples.original);
            m_trace_step            = m_samples_step;
         end
         m_samples.original  = wave_value(wave_sel, m_phase);
         m_samples.modulated = modulate_value(mod_sel, m_samples.original, m_lfsr[0]);
         m_samples_step      = m_step_count;
         m_phase             = m_phase + tuning_word;
         if (lfsr_stb)
         begin
            m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
            m_step_count++;
         end
         lfsr_stb  = (lfsr_cnt == LFSR_DIV - 1);
         lfsr_cnt  = lfsr_stb ? 0 : lfsr_cnt + 1;
         scope_stb = (scope_cnt == SCOPE_DIV - 1);
         scope_cnt = scope_stb ? 0 : scope_cnt + 1;
         for (int i = 0; i < KEY_COUNT; i++)
         begin
            if (key_event_valid && key_event[6:0] == MAKE_CODES[i])
            begin
               m_keys[i] = !key_event[7];  // make sets, break clears
            end
         end
      end
   end

   always @(negedge CLK_25MHZ)
   begin
      if (checking)
      begin
         check_value("held_keys", 32'(m_keys), 32'(held_keys));
         check_value("trace_valid", 32'(m_valid), 32'(trace_valid));
         if (trace_valid)
         begin
            check_value("modulated_trace", 32'(m_trace.modulated_trace),
                        32'(scope_trace.modulated_trace));
            check_value("original_trace", 32'(m_trace.original_trace),
                        32'(scope_trace.original_trace));
         end
      end
   end

   initial
   begin
      logic [31:0] r;
      logic [7:0]  first_pass [31];
      int          n;
      int          base;
      int          idx;

      test_name = "reset";
      reset_from_key  <= 1'b1;
      key_event_valid <= 1'b0;
      key_event       <= '0;
      tuning_word     <= '0;
      wave_sel        <= WAVE_SAW;
      mod_sel         <= MOD_NONE;
      repeat (5) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      checking = 1'b1;
      @(negedge CLK_25MHZ);
      check_value("held_keys after reset", 0, 32'(held_keys));
      check_value("trace_valid after reset", 0, 32'(trace_valid));
      n = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         n++;
      end while (!trace_valid && n < 20);
      check_value("first trace_valid cycle", 6, n);

      test_name = "held_keys";
      repeat (KEY_CYCLES)
      begin
         @(posedge CLK_25MHZ);
         r = next_random();
         key_event_valid <= r[0];
         key_event <= r[1] ? {r[2], MAKE_CODES[int'(r[31:8] % 24'd17)]} : r[15:8];
      end

      test_name = "waveforms";
      for (int w = 0; w < 4; w++)
      begin
         @(posedge CLK_25MHZ);
         r = next_random();
         key_event_valid <= 1'b0;
         wave_sel        <= wave_sel_t'(w);
         mod_sel         <= MOD_NONE;
         tuning_word     <= next_random() >> r[3:0];  // slow and fast carriers
         repeat (WAVE_CYCLES - 1) @(posedge CLK_25MHZ);
      end

      test_name = "modulation";
      for (int m = 1; m < 4; m++)
      begin
         @(posedge CLK_25MHZ);
         mod_sel <= mod_sel_t'(m);
         repeat (MOD_CYCLES / 100)
         begin
            r = next_random();
            wave_sel    <= wave_sel_t'(r[1:0]);
            tuning_word <= next_random() >> r[7:4];
            repeat (100) @(posedge CLK_25MHZ);
         end
      end

      ////////////////////
      // constant carrier so the ask trace shows only the prbs bit
      test_name = "lfsr_period";
      @(posedge CLK_25MHZ);
      wave_sel    <= WAVE_SQUARE;
      mod_sel     <= MOD_ASK;
      tuning_word <= '0;
      @(negedge CLK_25MHZ);
      base = m_step_count + 2;
      while (m_trace_step < base + 62)
      begin
         @(negedge CLK_25MHZ);
         idx = m_trace_step - base;
         if (m_valid && idx >= 0 && idx < 31)
         begin
            first_pass[idx] = m_trace.modulated_trace;  // modelled first period
         end
         else if (m_valid && idx >= 31 && idx < 62)
         begin
            check_value("pattern after 31 steps", 32'(first_pass[idx - 31]),
                        32'(scope_trace.modulated_trace));
         end
      end

      test_name = "live_changes";
      repeat (LIVE_CYCLES)
      begin
         @(posedge CLK_25MHZ);
         r = next_random();
         case (r[3:0])
            4'd0:    wave_sel    <= wave_sel_t'(r[9:8]);
            4'd1:    mod_sel     <= mod_sel_t'(r[9:8]);
            4'd2:    tuning_word <= next_random();
            default: r = r;  // keep the current settings
         endcase
      end
      @(negedge CLK_25MHZ);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/dds_scope_top.sv
`default_nettype none
`timescale 1ns/1ps

module dds_scope_top
   import dds_lab_pkg::*;
   import scan_code_pkg::*;
#(
   parameter int unsigned LFSR_DIVIDE  = LFSR_DIVIDE_DEFAULT,
   parameter int unsigned SCOPE_DIVIDE = SCOPE_DIVIDE_DEFAULT
) (
   input  wire logic               CLK_25MHZ,
   input  wire logic               reset_from_key,
   input  wire logic               key_event_valid,
   input  wire logic [7:0]         key_event,
   input  wire logic [PHASE_W-1:0] tuning_word,
   input  wire wave_sel_t          wave_sel,
   input  wire mod_sel_t           mod_sel,
   output held_keys_t              held_keys,
   output scope_trace_t            scope_trace,
   output logic                    trace_valid
);

   logic        lfsr_step;     // slow prbs rate
   logic        scope_strobe;  // scope sample rate
   logic        prbs_bit;
   dds_sample_t dds_samples;

   ////////////////////
   // keyboard

   held_key_tracker held_key_tracker_i (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .held_keys       (held_keys)
   );

   ////////////////////
   // rate strobes

   strobe_divider #(.DIVIDE(LFSR_DIVIDE)) lfsr_step_div (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .strobe         (lfsr_step)
   );

   strobe_divider #(.DIVIDE(SCOPE_DIVIDE)) scope_strobe_div (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .strobe         (scope_strobe)
   );

   ////////////////////
   // signal chain

   lfsr_prbs lfsr_prbs_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .step           (lfsr_step),
      .prbs_bit       (prbs_bit)
   );

   dds_modulator dds_modulator_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tuning_word    (tuning_word),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .prbs_bit       (prbs_bit),
      .samples        (dds_samples)
   );

   scope_sampler scope_sampler_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_strobe  (scope_strobe),
      .samples        (dds_samples),
      .scope_trace    (scope_trace),
      .trace_valid    (trace_valid)
   );

endmodule

`default_nettype wire

//--- rtl/scope_sampler.sv
`default_nettype none
`timescale 1ns/1ps

module scope_sampler
   import dds_lab_pkg::*;
(
   input  wire logic        CLK_25MHZ,
   input  wire logic        reset_from_key,
   input  wire logic        sample_strobe,
   input  wire dds_sample_t samples,
   output scope_trace_t     scope_trace,
   output logic             trace_valid
);

   // sign bit flipped, then the next seven magnitude bits
   function automatic logic [TRACE_W-1:0] to_offset(input logic [SAMPLE_W-1:0] s);
      return {~s[SAMPLE_W-1], s[SAMPLE_W-2 -: TRACE_W-1]};
   endfunction

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         scope_trace <= '0;
         trace_valid <= 1'b0;
      end
      else
      begin
         trace_valid <= sample_strobe;  // one cycle after the strobe
         if (sample_strobe)
         begin
            scope_trace.modulated_trace <= to_offset(samples.modulated);
            scope_trace.original_trace  <= to_offset(samples.original);
         end
      end
   end

   // a valid pulse always answers a strobe from the divider
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      trace_valid |-> $past(sample_strobe));

endmodule

`default_nettype wire

//--- rtl/dds_modulator.sv
`default_nettype none
`timescale 1ns/1ps

module dds_modulator
   import dds_lab_pkg::*;
(
   input  wire logic               CLK_25MHZ,
   input  wire logic               reset_from_key,
   input  wire logic [PHASE_W-1:0] tuning_word,
   input  wire wave_sel_t          wave_sel,
   input  wire mod_sel_t           mod_sel,
   input  wire logic               prbs_bit,
   output dds_sample_t             samples
);

   logic [PHASE_W-1:0]         phase;
   logic [SAMPLE_W-1:0]        p;           // top phase bits
   logic [SAMPLE_W-1:0]        q;           // low bits doubled
   logic signed [SAMPLE_W-1:0] saw_s;
   logic signed [SAMPLE_W-1:0] square_s;
   logic signed [SAMPLE_W-1:0] triangle_s;
   dds_sample_t                next_samples;

   ////////////////////
   // computed waveforms

   assign p = phase[PHASE_W-1 -: SAMPLE_W];
   assign q = {p[SAMPLE_W-2:0], 1'b0};

   assign saw_s    = {~p[SAMPLE_W-1], p[SAMPLE_W-2:0]};  // offset to two's complement
   assign square_s = p[SAMPLE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;

   // rising half then falling half, wraps modulo 4096
   assign triangle_s = p[SAMPLE_W-1] ? SAMPLE_MAX - q : q + SAMPLE_MIN;

   ////////////////////
   // selection and modulation

   always_comb
   begin
      case (wave_sel)
         WAVE_SAW:      next_samples.original = saw_s;
         WAVE_SQUARE:   next_samples.original = square_s;
         WAVE_TRIANGLE: next_samples.original = triangle_s;
         WAVE_ZERO:     next_samples.original = '0;
         default:       next_samples.original = '0;
      endcase

      case (mod_sel)
         MOD_ASK:
         begin
            next_samples.modulated = prbs_bit ? next_samples.original : '0;  // on off keying
         end
         MOD_BPSK:
         begin
            next_samples.modulated = prbs_bit ? next_samples.original
                                              : ~next_samples.original;
         end
         MOD_NONE, MOD_NONE_ALT:
         begin
            next_samples.modulated = next_samples.original;
         end
         default:
         begin
            next_samples.modulated = next_samples.original;
         end
      endcase
   end

   // samples lag the phase by one cycle
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase   <= '0;
         samples <= '0;
      end
      else
      begin
         phase   <= phase + tuning_word;  // free running accumulator
         samples <= next_samples;
      end
   end

endmodule

`default_nettype wire

//--- rtl/lfsr_prbs.sv
`default_nettype none
`timescale 1ns/1ps

module lfsr_prbs
   import dds_lab_pkg::*;
(
   input  wire logic CLK_25MHZ,
   input  wire logic reset_from_key,
   input  wire logic step,
   output logic      prbs_bit
);

   logic [LFSR_W-1:0] state;

   // x^5 + x^3 + 1, period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         state <= LFSR_SEED;
      end
      else if (step)
      begin
         state <= {state[LFSR_W-2:0], state[4] ^ state[2]};  // shift left, feed bit 0
      end
   end

   assign prbs_bit = state[0];

   // the all zero state would lock the sequence up
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      state != '0);

endmodule

`default_nettype wire

//--- rtl/strobe_divider.sv
`default_nettype none
`timescale 1ns/1ps

module strobe_divider #(
   parameter int unsigned DIVIDE = 2
) (
   input  wire logic CLK_25MHZ,
   input  wire logic reset_from_key,
   output logic      strobe
);

   localparam int               CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
   localparam logic [CNT_W-1:0] LAST  = CNT_W'(DIVIDE - 1);

   logic [CNT_W-1:0] count;
   logic             at_last;

   assign at_last = (count == LAST);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         count  <= '0;
         strobe <= 1'b0;
      end
      else
      begin
         count  <= at_last ? '0 : count + 1'b1;  // wrap every DIVIDE cycles
         strobe <= at_last;                      // registered, one cycle wide
      end
   end

   // divide by one is the only case with back to back strobes
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      ((DIVIDE > 1) && strobe) |=> !strobe);

endmodule

`default_nettype wire

//--- rtl/held_key_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module held_key_tracker
   import scan_code_pkg::*;
(
   input  wire logic       CLK_25MHZ,
   input  wire logic       reset_from_key,
   input  wire logic       key_event_valid,  // one cycle per event
   input  wire logic [7:0] key_event,
   output held_keys_t      held_keys
);

   held_keys_t held_next;

   // each matching key code follows the break flag
   always_comb
   begin
      logic [KEY_COUNT-1:0] bits;

      bits = held_keys;
      if (key_event_valid)
      begin
         for (int i = 0; i < KEY_COUNT; i++)
         begin
            if (key_event[KEY_CODE_W-1:0] == MAKE_CODES[i])
            begin
               bits[i] = ~key_event[BREAK_FLAG];  // make sets, break clears
            end
         end
      end
      held_next = held_keys_t'(bits);  // unknown codes fall through
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else
      begin
         held_keys <= held_next;
      end
   end

endmodule

`default_nettype wire

//--- rtl/scan_code_pkg.sv
`default_nettype none

package scan_code_pkg;

   localparam int KEY_COUNT  = 17;
   localparam int KEY_CODE_W = 7;   // event code without the break flag
   localparam int BREAK_FLAG = 7;   // bit position in the event byte

   ////////////////////
   // make codes, index matches the held_keys bit

   localparam logic [KEY_COUNT-1:0][KEY_CODE_W-1:0] MAKE_CODES = {
      7'h16,  // key_1
      7'h1e,  // key_2
      7'h26,  // key_3
      7'h25,  // key_4
      7'h2e,  // key_5
      7'h36,  // key_6
      7'h3d,  // key_7
      7'h3e,  // key_8
      7'h05,  // f1
      7'h06,  // f2
      7'h31,  // n
      7'h3a,  // m
      7'h29,  // space
      7'h6b,  // left arrow
      7'h74,  // right arrow
      7'h75,  // up arrow
      7'h72   // down arrow
   };

   typedef struct packed {
      logic key_1;
      logic key_2;
      logic key_3;
      logic key_4;
      logic key_5;
      logic key_6;
      logic key_7;
      logic key_8;
      logic f1;
      logic f2;
      logic n;
      logic m;
      logic space;
      logic left;
      logic right;
      logic up;
      logic down;
   } held_keys_t;

endpackage

`default_nettype wire

//--- rtl/dds_lab_pkg.sv
`default_nettype none

package dds_lab_pkg;

   ////////////////////
   // widths

   localparam int PHASE_W  = 32;  // accumulator and tuning word
   localparam int SAMPLE_W = 12;  // signed dds sample
   localparam int TRACE_W  = 8;   // offset binary scope trace
   localparam int LFSR_W   = 5;

   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;  // any nonzero state

   localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 12'sh7ff;  // +2047
   localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 12'sh800;  // -2048

   // divide ratios at 25 MHz
   localparam int unsigned LFSR_DIVIDE_DEFAULT  = 25_000_000;  // one step per second
   localparam int unsigned SCOPE_DIVIDE_DEFAULT = 70_000;

   ////////////////////
   // selector codes

   typedef enum logic [1:0] {
      WAVE_SAW      = 2'd0,
      WAVE_SQUARE   = 2'd1,
      WAVE_TRIANGLE = 2'd2,
      WAVE_ZERO     = 2'd3
   } wave_sel_t;

   typedef enum logic [1:0] {
      MOD_NONE     = 2'd0,
      MOD_ASK      = 2'd1,
      MOD_BPSK     = 2'd2,
      MOD_NONE_ALT = 2'd3   // spare code, behaves as none
   } mod_sel_t;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] modulated;
      logic signed [SAMPLE_W-1:0] original;
   } dds_sample_t;

   typedef struct packed {
      logic [TRACE_W-1:0] modulated_trace;
      logic [TRACE_W-1:0] original_trace;
   } scope_trace_t;

endpackage

`default_nettype wire
